//--- design/cpu_isa_pkg.sv
// CPU instruction set definitions
`default_nettype none

package cpu_isa_pkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0] reg_idx_t;

	// Low nibble of every instruction word
	typedef enum logic [3:0] {
		HALT  = 4'h0,
		MOV   = 4'h1,
		MOVNZ = 4'h2,
		MOVEZ = 4'h3,
		BUS   = 4'h4,
		MEMR  = 4'h5,
		SET   = 4'h6,
		MEMW  = 4'h7,
		AND   = 4'h8,
		OR    = 4'h9,
		XOR   = 4'hA,
		ADD   = 4'hB,
		SHFT  = 4'hC,
		MUL   = 4'hD,
		GT    = 4'hE,
		EQ    = 4'hF
	} opcode_e;

	// General view, upper nibble names the condition register
	typedef struct packed {
		reg_idx_t cond;
		reg_idx_t dst;
		reg_idx_t src;
		opcode_e  op;
	} insn_fields_t;

	// Shift view, upper nibble is direction plus amount
	typedef struct packed {
		logic       shift_left;
		logic [2:0] shift_amt;
		reg_idx_t   dst;
		reg_idx_t   src;
		opcode_e    op;
	} insn_shift_t;

	typedef union packed {
		insn_fields_t fields;
		insn_shift_t  shift;
	} insn_u;

endpackage

`default_nettype wire

//--- design/cpu_core_pkg.sv
// CPU core definitions
`default_nettype none

package cpu_core_pkg;

	localparam int NUM_REGS = 16;

	// Data addresses use the low 15 bits of a register
	localparam int MEM_ADDR_W = 15;

	localparam int PC_W = 16;

	// Sequencer, one pass per instruction
	typedef enum logic [1:0] {
		LOAD    = 2'd0,
		EXEC    = 2'd1,
		COMMIT  = 2'd2,
		ADVANCE = 2'd3
	} state_e;

	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

endpackage

`default_nettype wire

//--- design/cpu_regfile.sv
// CPU register file
`timescale 1ns/10ps
`default_nettype none

module cpu_regfile (
	input  logic                  clk,
	input  logic                  mem_read_ready_stor_reset,
	input  cpu_isa_pkg::reg_idx_t rd_idx,
	output cpu_isa_pkg::word_t    rd_data,
	input  cpu_isa_pkg::reg_idx_t wr_idx,
	input  cpu_isa_pkg::word_t    wr_data,
	input  logic                  wr_en,
	input  logic [1:0]            pc_step,
	output cpu_isa_pkg::word_t    pc
);
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;

	word_t regs [NUM_REGS];
	logic [PC_W-1:0] pc_q;

	// General registers
	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Program counter, zero step holds it
	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_q + PC_W'(pc_step);
		end
	end

	assign rd_data = regs[rd_idx];
	assign pc = pc_q;

endmodule

`default_nettype wire

//--- design/cpu_alu.sv
// CPU arithmetic and compare unit
`timescale 1ns/10ps
`default_nettype none

module cpu_alu (
	input  cpu_isa_pkg::word_t op_a,
	input  cpu_isa_pkg::word_t op_b,
	input  cpu_isa_pkg::insn_u insn,
	output cpu_isa_pkg::word_t result
);
	import cpu_isa_pkg::*;

	word_t product;

	// Only the low half of the product is kept
	assign product = op_a * op_b;

	always_comb begin
		result = '0;
		case (insn.fields.op)
			AND: begin
				result = op_a & op_b;
			end
			OR: begin
				result = op_a | op_b;
			end
			XOR: begin
				result = op_a ^ op_b;
			end
			ADD: begin
				result = op_a + op_b;
			end
			MUL: begin
				result = product;
			end
			GT: begin
				result = (op_a > op_b) ? 16'hFFFF : 16'h0000;
			end
			EQ: begin
				result = (op_a == op_b) ? 16'hFFFF : 16'h0000;
			end
			SHFT: begin
				// Right shifts take the whole upper nibble as amount
				if (insn.shift.shift_left) begin
					result = op_a << insn.shift.shift_amt;
				end else begin
					result = op_a >> insn.fields.cond;
				end
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/cpu_control.sv
// CPU sequencer and instruction control
`timescale 1ns/10ps
`default_nettype none

module cpu_control (
	input  logic                    clk,
	input  logic                    mem_read_ready_stor_reset,
	input  cpu_isa_pkg::word_t      prog_data,
	input  cpu_isa_pkg::word_t      pc,
	output logic [1:0]              pc_step,
	output cpu_isa_pkg::reg_idx_t   rd_idx,
	input  cpu_isa_pkg::word_t      rd_data,
	output cpu_isa_pkg::reg_idx_t   wr_idx,
	output cpu_isa_pkg::word_t      wr_data,
	output logic                    wr_en,
	output cpu_isa_pkg::word_t      alu_a,
	output cpu_isa_pkg::insn_u      alu_insn,
	input  cpu_isa_pkg::word_t      alu_result,
	output logic                    mem_req,
	output logic                    mem_we,
	output cpu_core_pkg::mem_addr_t mem_addr,
	output cpu_isa_pkg::word_t      mem_wdata,
	input  cpu_isa_pkg::word_t      mem_rdata,
	input  logic                    mem_ready,
	output logic                    halted
);
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;

	state_e state_q;
	logic [1:0] step_q;
	logic wr_pend_q;
	logic halted_q;

	insn_u insn_q;
	// Instruction address after LOAD, then the src operand
	word_t opa_q;
	word_t wdata_q;

	opcode_e op;
	logic cond_hit;

	assign op = insn_q.fields.op;

	// MOVNZ tests for nonzero, MOVEZ for zero
	assign cond_hit = (op == MOVNZ) ? (rd_data != '0) : (rd_data == '0);

	// Step 0 reads src, later steps read cond
	assign rd_idx = (step_q == 2'd0) ? insn_q.fields.src : insn_q.fields.cond;

	// SET moves the PC onto its data word, ADVANCE steps past it
	always_comb begin
		pc_step = 2'd0;
		if (state_q == ADVANCE) begin
			pc_step = 2'd1;
		end else if (state_q == EXEC && op == SET && pc == opa_q) begin
			pc_step = 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			state_q <= LOAD;
			step_q <= 2'd0;
			wr_pend_q <= 1'b0;
			halted_q <= 1'b0;
			mem_req <= 1'b0;
			mem_we <= 1'b0;
		end else begin
			case (state_q)
				LOAD: begin
					step_q <= 2'd0;
					state_q <= EXEC;
				end
				EXEC: begin
					case (op)
						HALT, BUS: begin
							halted_q <= 1'b1;
						end
						MOV: begin
							wr_pend_q <= 1'b1;
							state_q <= COMMIT;
						end
						MOVNZ, MOVEZ: begin
							if (step_q == 2'd0) begin
								step_q <= 2'd1;
							end else begin
								wr_pend_q <= cond_hit;
								state_q <= COMMIT;
							end
						end
						SET: begin
							if (pc != opa_q) begin
								wr_pend_q <= 1'b1;
								state_q <= COMMIT;
							end
						end
						MEMR: begin
							if (step_q == 2'd0) begin
								mem_req <= 1'b1;
								mem_we <= 1'b0;
								step_q <= 2'd1;
							end else if (mem_ready) begin
								mem_req <= 1'b0;
								wr_pend_q <= 1'b1;
								state_q <= COMMIT;
							end
						end
						MEMW: begin
							// Address first, then data from cond
							if (step_q == 2'd0) begin
								step_q <= 2'd1;
							end else if (step_q == 2'd1) begin
								mem_req <= 1'b1;
								mem_we <= 1'b1;
								step_q <= 2'd2;
							end else if (mem_ready) begin
								mem_req <= 1'b0;
								mem_we <= 1'b0;
								state_q <= COMMIT;
							end
						end
						default: begin
							if (step_q == 2'd0) begin
								step_q <= 2'd1;
							end else begin
								wr_pend_q <= 1'b1;
								state_q <= COMMIT;
							end
						end
					endcase
				end
				COMMIT: begin
					wr_pend_q <= 1'b0;
					state_q <= ADVANCE;
				end
				default: begin
					state_q <= LOAD;
				end
			endcase
		end
	end

	// Instruction word and operands
	always_ff @(posedge clk) begin
		if (state_q == LOAD) begin
			insn_q <= prog_data;
			opa_q <= pc;
		end else if (state_q == EXEC) begin
			if (step_q == 2'd0 && op != SET) begin
				opa_q <= rd_data;
			end
			case (op)
				MOV, MOVNZ, MOVEZ: begin
					if (step_q == 2'd0) begin
						wdata_q <= rd_data;
					end
				end
				SET: begin
					if (pc != opa_q) begin
						wdata_q <= prog_data;
					end
				end
				MEMR: begin
					if (mem_req && mem_ready) begin
						wdata_q <= mem_rdata;
					end
				end
				MEMW: begin
					if (step_q == 2'd1) begin
						wdata_q <= rd_data;
					end
				end
				HALT, BUS: begin
				end
				default: begin
					if (step_q == 2'd1) begin
						wdata_q <= alu_result;
					end
				end
			endcase
		end
	end

	assign wr_idx = insn_q.fields.dst;
	assign wr_data = wdata_q;
	assign wr_en = (state_q == COMMIT) && wr_pend_q;

	assign alu_a = opa_q;
	assign alu_insn = insn_q;

	assign mem_addr = opa_q[MEM_ADDR_W-1:0];
	assign mem_wdata = wdata_q;

	assign halted = halted_q;

endmodule

`default_nettype wire

//--- design/cpu_top.sv
// CPU core top level
`timescale 1ns/10ps
`default_nettype none

module cpu_top (
	input  logic                    clk,
	input  logic                    mem_read_ready_stor_reset,
	output cpu_isa_pkg::word_t      prog_addr,
	input  cpu_isa_pkg::word_t      prog_data,
	output logic                    mem_req,
	output logic                    mem_we,
	output cpu_core_pkg::mem_addr_t mem_addr,
	output cpu_isa_pkg::word_t      mem_wdata,
	input  cpu_isa_pkg::word_t      mem_rdata,
	input  logic                    mem_ready,
	output logic                    halted
);
	import cpu_isa_pkg::*;

	reg_idx_t rd_idx;
	word_t rd_data;
	reg_idx_t wr_idx;
	word_t wr_data;
	logic wr_en;
	logic [1:0] pc_step;
	word_t alu_a;
	insn_u alu_insn;
	word_t alu_result;

	cpu_control cpu_control_i (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.prog_data                 (prog_data),
		.pc                        (prog_addr),
		.pc_step                   (pc_step),
		.rd_idx                    (rd_idx),
		.rd_data                   (rd_data),
		.wr_idx                    (wr_idx),
		.wr_data                   (wr_data),
		.wr_en                     (wr_en),
		.alu_a                     (alu_a),
		.alu_insn                  (alu_insn),
		.alu_result                (alu_result),
		.mem_req                   (mem_req),
		.mem_we                    (mem_we),
		.mem_addr                  (mem_addr),
		.mem_wdata                 (mem_wdata),
		.mem_rdata                 (mem_rdata),
		.mem_ready                 (mem_ready),
		.halted                    (halted)
	);

	// Program counter doubles as the fetch address
	cpu_regfile cpu_regfile_i (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.rd_idx                    (rd_idx),
		.rd_data                   (rd_data),
		.wr_idx                    (wr_idx),
		.wr_data                   (wr_data),
		.wr_en                     (wr_en),
		.pc_step                   (pc_step),
		.pc                        (prog_addr)
	);

	cpu_alu cpu_alu_i (
		.op_a   (alu_a),
		.op_b   (rd_data),
		.insn   (alu_insn),
		.result (alu_result)
	);

endmodule

`default_nettype wire

//--- dv/cpu_tb_clock.sv
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module cpu_tb_clock (
	output logic clk,
	output logic mem_read_ready_stor_reset
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset held over the first 10 rising edges, released on a falling edge
	initial begin
		mem_read_ready_stor_reset = 1'b1;
		repeat (10) @(negedge clk);
		mem_read_ready_stor_reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- dv/cpu_tb.sv
// CPU core testbench
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;

	localparam int PROG_WORDS = 1024;
	localparam int MEM_WORDS = 1 << MEM_ADDR_W;
	localparam int RUN_LIMIT = 20000;

	logic clk;
	logic mem_read_ready_stor_reset;
	word_t prog_addr;
	word_t prog_data;
	logic mem_req;
	logic mem_we;
	mem_addr_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;
	logic mem_ready;
	logic halted;

	word_t prog_mem [PROG_WORDS];
	word_t data_mem [MEM_WORDS];
	word_t model_mem [MEM_WORDS];
	word_t model_regs [NUM_REGS];
	word_t pc_trace_q [$];
	// Expected transfers as {we, addr, data}
	logic [31:0] xfer_q [$];
	word_t halt_pc;

	cpu_tb_clock cpu_tb_clock_i (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset)
	);

	cpu_top cpu_top_i (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.prog_addr                 (prog_addr),
		.prog_data                 (prog_data),
		.mem_req                   (mem_req),
		.mem_we                    (mem_we),
		.mem_addr                  (mem_addr),
		.mem_wdata                 (mem_wdata),
		.mem_rdata                 (mem_rdata),
		.mem_ready                 (mem_ready),
		.halted                    (halted)
	);

	assign prog_data = prog_mem[prog_addr[9:0]];

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
			abort_run();
		end
	endtask

	// Odd multiplier keeps every address bit in the pattern
	function automatic word_t fill_word(input mem_addr_t addr);
		return (16'(addr) * 16'h9E37) ^ 16'h3C5A;
	endfunction

	task automatic build_program();
		insn_u insn;
		reg_idx_t dst;
		int n;
		int op;
		n = 0;
		for (int i = 0; i < PROG_WORDS; i++) begin
			prog_mem[i] = '0;
		end
		for (int r = 0; r < NUM_REGS; r++) begin
			insn = '0;
			insn.fields.dst = reg_idx_t'(r);
			insn.fields.op = SET;
			prog_mem[n] = insn;
			prog_mem[n + 1] = word_t'($urandom);
			n = n + 2;
		end
		for (int i = 0; i < 200; i++) begin
			op = $urandom_range(1, 15);
			if (op == BUS) begin
				op = MOV;
			end
			insn = word_t'($urandom);
			insn.fields.op = opcode_e'(op);
			prog_mem[n] = insn;
			n++;
			if (op == SET) begin
				prog_mem[n] = word_t'($urandom);
				n++;
			end
			// Sometimes store the result to a random address
			if ($urandom_range(0, 1) == 1) begin
				dst = insn.fields.dst;
				insn = word_t'($urandom);
				insn.fields.cond = dst;
				insn.fields.op = MEMW;
				prog_mem[n] = insn;
				n++;
			end
		end
		prog_mem[n] = '0;
	endtask

	function automatic word_t alu_model(input word_t w, input word_t a, input word_t b);
		logic [31:0] prod;
		prod = a * b;
		case (w[3:0])
			AND: return a & b;
			OR: return a | b;
			XOR: return a ^ b;
			ADD: return a + b;
			MUL: return prod[15:0];
			GT: return (a > b) ? 16'hFFFF : 16'h0000;
			EQ: return (a == b) ? 16'hFFFF : 16'h0000;
			SHFT: return w[15] ? (a << w[14:12]) : (a >> w[15:12]);
			default: return '0;
		endcase
	endfunction

	task automatic run_model();
		insn_u insn;
		word_t pc;
		word_t a;
		word_t c;
		mem_addr_t addr;
		logic done;
		pc = '0;
		done = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			model_mem[i] = fill_word(mem_addr_t'(i));
		end
		for (int step = 0; step < PROG_WORDS && !done; step++) begin
			insn = prog_mem[pc[9:0]];
			a = model_regs[insn.fields.src];
			c = model_regs[insn.fields.cond];
			addr = a[MEM_ADDR_W-1:0];
			if (insn.fields.op == HALT || insn.fields.op == BUS) begin
				halt_pc = pc;
				done = 1'b1;
			end else begin
				case (insn.fields.op)
					MOV: model_regs[insn.fields.dst] = a;
					MOVNZ: begin
						if (c != '0) begin
							model_regs[insn.fields.dst] = a;
						end
					end
					MOVEZ: begin
						if (c == '0) begin
							model_regs[insn.fields.dst] = a;
						end
					end
					SET: begin
						pc = pc + 1'b1;
						pc_trace_q.push_back(pc);
						model_regs[insn.fields.dst] = prog_mem[pc[9:0]];
					end
					MEMR: begin
						xfer_q.push_back({1'b0, addr, 16'h0000});
						model_regs[insn.fields.dst] = model_mem[addr];
					end
					MEMW: begin
						xfer_q.push_back({1'b1, addr, c});
						model_mem[addr] = c;
					end
					default: model_regs[insn.fields.dst] = alu_model(insn, a, c);
				endcase
				pc = pc + 1'b1;
				pc_trace_q.push_back(pc);
			end
		end
		if (!done) begin
			$display("Reference model ran off the program without reaching a HALT");
			abort_run();
		end
	endtask

	initial begin
		mem_addr_t req_addr;
		word_t req_wdata;
		logic req_we;
		logic req_active;
		logic [31:0] xfer;
		int delay_left;
		int cycles;
		word_t last_addr;

		mem_ready = 1'b0;
		mem_rdata = '0;
		void'($urandom(32'he23f5555));
		for (int i = 0; i < MEM_WORDS; i++) begin
			data_mem[i] = fill_word(mem_addr_t'(i));
		end
		for (int r = 0; r < NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		build_program();
		run_model();
		req_active = 1'b0;
		req_we = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		delay_left = 0;

		cycles = 0;
		while (mem_read_ready_stor_reset !== 1'b0) begin
			if (cycles == 100) begin
				$display("Reset was never released");
				abort_run();
			end
			@(negedge clk);
			cycles++;
		end
		check_value("reset mem_req", 0, mem_req);
		check_value("reset halted", 0, halted);
		check_value("reset prog_addr", 0, prog_addr);
		last_addr = prog_addr;

		cycles = 0;
		while (halted !== 1'b1) begin
			if (cycles == RUN_LIMIT) begin
				$display("Timeout waiting for the core to halt");
				abort_run();
			end
			@(negedge clk);
			cycles++;
			if (prog_addr !== last_addr) begin
				if (pc_trace_q.size() == 0) begin
					$display("Program address moved beyond the expected trace");
					abort_run();
				end
				check_value("pc trace", pc_trace_q.pop_front(), prog_addr);
				last_addr = prog_addr;
			end
			if (mem_ready) begin
				check_value("mem_req after ready", 0, mem_req);
				mem_ready = 1'b0;
				mem_rdata = word_t'($urandom);
			end else if (mem_req) begin
				if (!req_active) begin
					if (xfer_q.size() == 0) begin
						$display("Unexpected memory request from the core");
						abort_run();
					end
					xfer = xfer_q.pop_front();
					check_value("mem_we", xfer[31], mem_we);
					check_value("mem_addr", xfer[30:16], mem_addr);
					if (xfer[31]) begin
						check_value("mem_wdata", xfer[15:0], mem_wdata);
					end
					req_active = 1'b1;
					req_we = mem_we;
					req_addr = mem_addr;
					req_wdata = mem_wdata;
					delay_left = $urandom_range(0, 4);
				end else begin
					check_value("stable mem_we", req_we, mem_we);
					check_value("stable mem_addr", req_addr, mem_addr);
					check_value("stable mem_wdata", req_wdata, mem_wdata);
				end
				if (delay_left == 0) begin
					if (req_we) begin
						data_mem[req_addr] = req_wdata;
					end else begin
						mem_rdata = data_mem[req_addr];
					end
					mem_ready = 1'b1;
					req_active = 1'b0;
				end else begin
					delay_left--;
				end
			end else if (req_active) begin
				$display("Core dropped mem_req before mem_ready");
				abort_run();
			end
		end

		check_value("halt pc", halt_pc, prog_addr);
		check_value("pc trace left", 0, pc_trace_q.size());
		check_value("transfers left", 0, xfer_q.size());
		for (int i = 0; i < 50; i++) begin
			@(negedge clk);
			check_value("halted hold", 1, halted);
			check_value("halt prog_addr hold", halt_pc, prog_addr);
			check_value("halt mem_req hold", 0, mem_req);
		end

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
design/cpu_isa_pkg.sv
design/cpu_core_pkg.sv
design/cpu_regfile.sv
design/cpu_alu.sv
design/cpu_control.sv
design/cpu_top.sv
dv/cpu_tb_clock.sv
dv/cpu_tb.sv
